// ==== common/hamming_config.svh ====
// Hamming store configuration
`ifndef HAMMING_CONFIG_SVH
`define HAMMING_CONFIG_SVH

// store geometry
`define HAM_DEPTH       16
`define HAM_ADDR_W      4

// pipeline latencies in clock cycles
`define HAM_ENC_LAT     2
`define HAM_DEC_LAT     3
`define HAM_RAM_RD_LAT  1

// counter widths
`define HAM_TIMER_W     3
`define HAM_CNT_W       8

`endif

// ==== common/hamming_pkg.sv ====
// Hamming(31,26) shared types
`include "hamming_config.svh"

package hamming_pkg;

    localparam int DATA_W = 26;
    localparam int CODE_W = 31;
    localparam int SYN_W  = 5;

    typedef logic [DATA_W-1:0]          data_word_t;
    typedef logic [CODE_W-1:0]          code_word_t;
    typedef logic [SYN_W-1:0]           syndrome_t;
    typedef logic [$clog2(CODE_W)-1:0]  bit_index_t;
    typedef logic [`HAM_ADDR_W-1:0]     addr_t;
    typedef logic [`HAM_CNT_W-1:0]      err_count_t;

    typedef enum logic [1:0] {
        IDLE,
        ENC_WAIT,
        RD_WAIT,
        ACK_HOLD
    } ctrl_state_t;

    // xor of the 1-based positions of all set bits
    // zero for a valid codeword, else the position of a single flip
    function automatic syndrome_t calc_syndrome(input code_word_t c);
        syndrome_t s;
        s = '0;
        for (int i = 0; i < CODE_W; i++) begin
            if (c[i]) begin
                s = s ^ syndrome_t'(i + 1);
            end
        end
        return s;
    endfunction

endpackage

// ==== codec/hamming_encoder.sv ====
// Hamming(31,26) pipelined encoder
`timescale 1ns/1ps

module hamming_encoder
    import hamming_pkg::*;
(
    input  logic       clk,
    input  data_word_t data,
    output code_word_t code
);

    code_word_t placed;

    // spread data over the non power-of-two positions, parity slots left zero
    function automatic code_word_t place_data(input data_word_t d);
        code_word_t c;
        int k;
        c = '0;
        k = 0;
        for (int i = 0; i < CODE_W; i++) begin
            // position i+1 is a power of two when (i+1) & i is zero
            if (((i + 1) & i) != 0) begin
                c[i] = d[k];
                k++;
            end
        end
        return c;
    endfunction

    // parity bit j covers every position with bit j set
    // the syndrome of the parity-free word gives all five at once
    function automatic code_word_t add_parity(input code_word_t c);
        code_word_t r;
        syndrome_t s;
        r = c;
        s = calc_syndrome(c);
        for (int j = 0; j < SYN_W; j++) begin
            r[(1 << j) - 1] = s[j];
        end
        return r;
    endfunction

    // stage 1
    always_ff @(posedge clk) begin
        placed <= place_data(data);
    end

    // stage 2
    always_ff @(posedge clk) begin
        code <= add_parity(placed);
    end

endmodule

// ==== codec/hamming_decoder.sv ====
// Hamming(31,26) pipelined decoder
`timescale 1ns/1ps

module hamming_decoder
    import hamming_pkg::*;
(
    input  logic       clk,
    input  code_word_t code,
    output data_word_t data,
    output logic       corrected
);

    // stage 1 registers
    code_word_t code_q1;
    syndrome_t  syn_q1;

    // stage 2 registers
    code_word_t fixed_q2;
    logic       err_q2;

    // pull the data bits back out of the non power-of-two positions
    function automatic data_word_t extract_data(input code_word_t c);
        data_word_t d;
        int k;
        d = '0;
        k = 0;
        for (int i = 0; i < CODE_W; i++) begin
            if (((i + 1) & i) != 0) begin
                d[k] = c[i];
                k++;
            end
        end
        return d;
    endfunction

    // stage 1: syndrome alongside the raw word
    always_ff @(posedge clk) begin
        code_q1 <= code;
        syn_q1  <= calc_syndrome(code);
    end

    // stage 2: single-bit correction
    // syndrome 31 maps to index 30, so every nonzero value is in range
    always_ff @(posedge clk) begin
        if (syn_q1 != '0) begin
            fixed_q2 <= code_q1 ^ (code_word_t'(1) << (syn_q1 - 5'd1));
        end else begin
            fixed_q2 <= code_q1;
        end
        err_q2 <= (syn_q1 != '0);
    end

    // stage 3: data extraction
    always_ff @(posedge clk) begin
        data      <= extract_data(fixed_q2);
        corrected <= err_q2;
    end

endmodule

// ==== src/codeword_ram.sv ====
// Codeword storage with fault injection
`timescale 1ns/1ps

`include "hamming_config.svh"

module codeword_ram
    import hamming_pkg::*;
(
    input  logic       clk,
    input  logic       we,
    input  addr_t      waddr,
    input  code_word_t wdata,
    input  addr_t      raddr,
    output code_word_t rdata,
    input  logic       flip,
    input  addr_t      flip_addr,
    input  bit_index_t flip_bit
);

    code_word_t mem [`HAM_DEPTH];

    logic flip_hits_write;

    // a flip on the entry being written wins over the write
    assign flip_hits_write = flip && (flip_addr == waddr);

    always_ff @(posedge clk) begin
        if (we && !flip_hits_write) begin
            mem[waddr] <= wdata;
        end
        if (flip) begin
            // one-hot upset of the selected cell
            mem[flip_addr] <= mem[flip_addr] ^ (code_word_t'(1) << flip_bit);
        end
    end

    // registered read, one cycle after raddr
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== src/latency_timer.sv ====
// Pipeline wait timer
`timescale 1ns/1ps

`include "hamming_config.svh"

module latency_timer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load,
    input  logic [`HAM_TIMER_W-1:0] load_value,
    output logic                    done
);

    logic [`HAM_TIMER_W-1:0] count;
    logic                    busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (load) begin
            count <= load_value;
            busy  <= 1'b1;
        end else if (busy) begin
            if (count == '0) begin
                // back to idle after the done cycle
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // single-cycle pulse once the count has run out
    assign done = busy && (count == '0);

endmodule

// ==== src/op_controller.sv ====
// Handshake and operation sequencer
`timescale 1ns/1ps

`include "hamming_config.svh"

module op_controller
    import hamming_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    input  logic                    we,
    input  addr_t                   addr,
    input  data_word_t              wdata,
    input  data_word_t              dec_data,
    input  logic                    dec_corrected,
    input  logic                    timer_done,
    output logic                    ack,
    output data_word_t              rdata,
    output logic                    corrected,
    output err_count_t              corrected_count,
    output data_word_t              enc_data,
    output logic                    ram_we,
    output addr_t                   ram_addr,
    output logic                    timer_load,
    output logic [`HAM_TIMER_W-1:0] timer_value
);

    // done is seen one cycle after the count reaches zero
    // write: encoder latency, then the write cycle itself
    localparam logic [`HAM_TIMER_W-1:0] wr_wait = `HAM_TIMER_W'(`HAM_ENC_LAT + 1);
    // read: ram read plus the decoder pipeline
    localparam logic [`HAM_TIMER_W-1:0] rd_wait = `HAM_TIMER_W'(`HAM_RAM_RD_LAT + `HAM_DEC_LAT);

    ctrl_state_t state;

    logic start;

    assign start = (state == IDLE) && req;

    assign timer_load  = start;
    assign timer_value = we ? wr_wait : rd_wait;

    // encoded word is ready by the time done arrives
    assign ram_we = (state == ENC_WAIT) && timer_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= IDLE;
            ack             <= 1'b0;
            corrected       <= 1'b0;
            corrected_count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= we ? ENC_WAIT : RD_WAIT;
                    end
                end
                ENC_WAIT: begin
                    if (timer_done) begin
                        corrected <= 1'b0;
                        ack       <= 1'b1;
                        state     <= ACK_HOLD;
                    end
                end
                RD_WAIT: begin
                    if (timer_done) begin
                        corrected <= dec_corrected;
                        // saturate rather than wrap
                        if (dec_corrected && corrected_count != '1) begin
                            corrected_count <= corrected_count + 1'b1;
                        end
                        ack   <= 1'b1;
                        state <= ACK_HOLD;
                    end
                end
                ACK_HOLD: begin
                    // host owns the length of the ack phase
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload and read result
    always_ff @(posedge clk) begin
        if (start) begin
            ram_addr <= addr;
            enc_data <= wdata;
        end
        if (state == RD_WAIT && timer_done) begin
            rdata <= dec_data;
        end
    end

endmodule

// ==== src/ecc_store_top.sv ====
// ECC word store top level
`timescale 1ns/1ps

`include "hamming_config.svh"

module ecc_store_top
    import hamming_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  logic       we,
    input  addr_t      addr,
    input  data_word_t wdata,
    output logic       ack,
    output data_word_t rdata,
    output logic       corrected,
    output err_count_t corrected_count,
    input  logic       flip,
    input  addr_t      flip_addr,
    input  bit_index_t flip_bit
);

    data_word_t enc_data;
    code_word_t enc_code;
    code_word_t ram_rdata;
    data_word_t dec_data;
    logic       dec_corrected;
    logic       ram_we;
    addr_t      ram_addr;

    logic                    timer_load;
    logic [`HAM_TIMER_W-1:0] timer_value;
    logic                    timer_done;

    op_controller u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .we              (we),
        .addr            (addr),
        .wdata           (wdata),
        .dec_data        (dec_data),
        .dec_corrected   (dec_corrected),
        .timer_done      (timer_done),
        .ack             (ack),
        .rdata           (rdata),
        .corrected       (corrected),
        .corrected_count (corrected_count),
        .enc_data        (enc_data),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .timer_load      (timer_load),
        .timer_value     (timer_value)
    );

    latency_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .load       (timer_load),
        .load_value (timer_value),
        .done       (timer_done)
    );

    hamming_encoder u_enc (
        .clk  (clk),
        .data (enc_data),
        .code (enc_code)
    );

    // one address serves both ports
    codeword_ram u_ram (
        .clk       (clk),
        .we        (ram_we),
        .waddr     (ram_addr),
        .wdata     (enc_code),
        .raddr     (ram_addr),
        .rdata     (ram_rdata),
        .flip      (flip),
        .flip_addr (flip_addr),
        .flip_bit  (flip_bit)
    );

    hamming_decoder u_dec (
        .clk       (clk),
        .code      (ram_rdata),
        .data      (dec_data),
        .corrected (dec_corrected)
    );

endmodule

// ==== tb/ecc_store_tb.sv ====
// ECC word store testbench
`timescale 1ns/1ps

`include "hamming_config.svh"

module ecc_store_tb
    import hamming_pkg::*;
();

    // twenty cycles per handshake plus slack for the flips
    localparam int num_trans      = 16 * 2 + 31 * 2 + 2 + 200;
    localparam int timeout_cycles = num_trans * 20 + 1000;

    logic       clk;
    logic       reset;
    logic       req;
    logic       we;
    addr_t      addr;
    data_word_t wdata;
    logic       ack;
    data_word_t rdata;
    logic       corrected;
    err_count_t corrected_count;
    logic       flip;
    addr_t      flip_addr;
    bit_index_t flip_bit;

    code_word_t shadow [`HAM_DEPTH];
    err_count_t exp_count;
    int         errors;
    int         last_errors;
    int         tests_passed;
    int         tests_failed;
    int         cycles = 0;

    ecc_store_top UUT (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .we              (we),
        .addr            (addr),
        .wdata           (wdata),
        .ack             (ack),
        .rdata           (rdata),
        .corrected       (corrected),
        .corrected_count (corrected_count),
        .flip            (flip),
        .flip_addr       (flip_addr),
        .flip_bit        (flip_bit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // parity sits at the power-of-two positions 1, 2, 4, 8, 16
    function automatic bit is_parity_pos(input int p);
        return (p == 1) || (p == 2) || (p == 4) || (p == 8) || (p == 16);
    endfunction

    function automatic code_word_t ref_encode(input data_word_t d);
        code_word_t c;
        int k;
        c = '0;
        k = 0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (!is_parity_pos(p)) begin
                c[p-1] = d[k];
                k++;
            end
        end
        // each parity bit covers the positions with its bit set
        for (int j = 0; j < SYN_W; j++) begin
            for (int p = 1; p <= CODE_W; p++) begin
                if (((p >> j) & 1) == 1 && p != (1 << j)) begin
                    c[(1 << j) - 1] = c[(1 << j) - 1] ^ c[p-1];
                end
            end
        end
        return c;
    endfunction

    function automatic data_word_t ref_decode(input code_word_t c, output logic syn_nz);
        syndrome_t s;
        code_word_t f;
        data_word_t d;
        int k;
        s = '0;
        for (int j = 0; j < SYN_W; j++) begin
            for (int p = 1; p <= CODE_W; p++) begin
                if (((p >> j) & 1) == 1) begin
                    s[j] = s[j] ^ c[p-1];
                end
            end
        end
        f = c;
        if (s != '0) begin
            f[int'(s) - 1] = ~f[int'(s) - 1];
        end
        d = '0;
        k = 0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (!is_parity_pos(p)) begin
                d[k] = f[p-1];
                k++;
            end
        end
        syn_nz = (s != '0);
        return d;
    endfunction

    task automatic check_data(input string name, input data_word_t exp, input data_word_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input err_count_t exp, input err_count_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == last_errors) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors - last_errors);
        end
        last_errors = errors;
    endtask

    // returns on a falling edge with ack at the wanted level
    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (ack !== level) begin
            errors++;
            if (level) begin
                $display("handshake: ack never arrived within 20 cycles");
            end else begin
                $display("handshake: ack never dropped within 20 cycles");
            end
        end
    endtask

    task automatic host_write(input addr_t a, input data_word_t d);
        @(negedge clk);
        req   = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        wait_ack(1'b1);
        req = 1'b0;
        wait_ack(1'b0);
        shadow[a] = ref_encode(d);
    endtask

    task automatic host_read(input addr_t a, output data_word_t d, output logic c);
        @(negedge clk);
        req  = 1'b1;
        we   = 1'b0;
        addr = a;
        wait_ack(1'b1);
        d   = rdata;
        c   = corrected;
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic inject_flip(input addr_t a, input bit_index_t b);
        @(negedge clk);
        flip      = 1'b1;
        flip_addr = a;
        flip_bit  = b;
        @(negedge clk);
        flip = 1'b0;
        shadow[a][b] = ~shadow[a][b];
    endtask

    // counter model saturates like the hardware
    task automatic count_prediction(input addr_t a);
        logic nz;
        void'(ref_decode(shadow[a], nz));
        if (nz && exp_count != '1) begin
            exp_count = exp_count + 1'b1;
        end
    endtask

    task automatic read_and_check(input string name, input addr_t a);
        data_word_t exp_d;
        data_word_t act_d;
        logic exp_c;
        logic act_c;
        exp_d = ref_decode(shadow[a], exp_c);
        count_prediction(a);
        host_read(a, act_d, act_c);
        check_data(name, exp_d, act_d);
        check_flag(name, exp_c, act_c);
    endtask

    initial begin
        addr_t      a;
        data_word_t word;
        data_word_t written [`HAM_DEPTH];
        data_word_t act_d;
        logic       act_c;
        int         b1;
        int         b2;
        void'($urandom(32'h267d));
        reset = 1'b1;
        req = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        flip = 1'b0;
        flip_addr = '0;
        flip_bit = '0;
        exp_count = '0;
        errors = 0;
        last_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        check_flag("reset_state ack", 1'b0, ack);
        check_flag("reset_state corrected", 1'b0, corrected);
        check_count("reset_state count", '0, corrected_count);
        end_test("reset_state");

        // fixed patterns in the low entries then random words
        for (int i = 0; i < `HAM_DEPTH; i++) begin
            case (i)
                0: word = '0;
                1: word = '1;
                2: word = 26'h2aaaaaa;
                3: word = 26'h1555555;
                default: word = data_word_t'($urandom);
            endcase
            host_write(addr_t'(i), word);
            written[i] = word;
        end
        for (int i = 0; i < `HAM_DEPTH; i++) begin
            a = addr_t'(i);
            host_read(a, act_d, act_c);
            check_data($sformatf("clean_round_trip addr %0d", i), written[i], act_d);
            check_flag($sformatf("clean_round_trip addr %0d", i), 1'b0, act_c);
        end
        end_test("clean_round_trip");

        for (int b = 0; b < CODE_W; b++) begin
            a = addr_t'(b % `HAM_DEPTH);
            word = data_word_t'($urandom);
            host_write(a, word);
            inject_flip(a, bit_index_t'(b));
            count_prediction(a);
            host_read(a, act_d, act_c);
            check_data($sformatf("single_bit_correction bit %0d", b), word, act_d);
            check_flag($sformatf("single_bit_correction bit %0d", b), 1'b1, act_c);
        end
        end_test("single_bit_correction");

        // two distinct upsets give a miscorrection the model predicts
        b1 = int'($urandom % 31);
        b2 = (b1 + 1 + int'($urandom % 30)) % 31;
        host_write(addr_t'(5), data_word_t'($urandom));
        inject_flip(addr_t'(5), bit_index_t'(b1));
        inject_flip(addr_t'(5), bit_index_t'(b2));
        read_and_check($sformatf("double_flip bits %0d %0d", b1, b2), addr_t'(5));
        end_test("double_flip");

        check_count("correction_count", exp_count, corrected_count);
        end_test("correction_count");

        for (int n = 0; n < 200; n++) begin
            a = addr_t'($urandom % `HAM_DEPTH);
            if ($urandom % 2 == 0) begin
                host_write(a, data_word_t'($urandom));
            end else begin
                read_and_check($sformatf("random_stress op %0d", n), a);
            end
            if ($urandom % 4 == 0) begin
                inject_flip(addr_t'($urandom % `HAM_DEPTH), bit_index_t'($urandom % 31));
            end
        end
        check_count("random_stress count", exp_count, corrected_count);
        end_test("random_stress");

        $display("tests passed: %0d, tests with mismatches: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/hamming_pkg.sv
codec/hamming_encoder.sv
codec/hamming_decoder.sv
src/codeword_ram.sv
src/latency_timer.sv
src/op_controller.sv
src/ecc_store_top.sv
tb/ecc_store_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ECC store simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f verilog.f --top-module ecc_store_tb -o ecc_store_sim

./obj_dir/ecc_store_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
